//--- verilog/sound_pkg.sv
// sound peripheral shared definitions
// widths, base vectors, register map, host port types and the
// write-data union decoded as mode fields or as a DAC sample word

package sound_pkg;

  ////////////////////////////////////////////////////////////
  // sizes and vectors

  localparam int CYCLE_CLKS = 8;   // CLK edges per machine cycle
  localparam int TC_W       = 9;
  localparam int N_W        = 8;
  localparam int NUC_W      = 3;
  localparam int PNC_W      = 7;
  localparam int DATA_W     = 10;
  localparam int VEC_W      = 8;

  localparam logic [VEC_W-1:0] VEC_TONE = 8'h20;  // plus range offset
  localparam logic [VEC_W-1:0] VEC_NS   = 8'h48;
  localparam logic [VEC_W-1:0] VEC_TIME = 8'h80;

  ////////////////////////////////////////////////////////////
  // register map and host port

  typedef enum logic [1:0] {
    ADDR_MD = 2'd0,
    ADDR_N  = 2'd1,
    ADDR_DA = 2'd2,
    ADDR_RG = 2'd3   // read only
  } reg_addr_e;

  typedef struct packed {
    logic [1:0] ns_rate;   // NS trigger source select
    logic [3:0] unused;
    logic       time_ie;
    logic       nss_unused;
    logic       ns_ie;
    logic       tone_ie;
  } md_fields_t;

  typedef struct packed {
    logic              invert;  // complement magnitude
    logic              neg;     // negative half of the waveform
    logic [DATA_W-3:0] magnitude;
  } da_word_t;

  // same write word, seen through the register it targets
  typedef union packed {
    md_fields_t md;
    da_word_t   da;
  } wr_data_u;

  typedef struct packed {
    logic      valid;
    reg_addr_e addr;
    wr_data_u  data;
  } reg_wr_t;

  typedef struct packed {
    logic      valid;
    reg_addr_e addr;
  } reg_rd_t;

  ////////////////////////////////////////////////////////////
  // tone ranges and interrupts

  typedef enum logic [2:0] {
    RANGE_00_07,
    RANGE_08_0F,
    RANGE_10_1F,
    RANGE_20_3F,
    RANGE_40_FF
  } tone_range_e;

  // lower value wins
  typedef enum logic [1:0] {
    INT_TONE = 2'd0,
    INT_NS   = 2'd1,
    INT_TIME = 2'd2
  } int_src_e;

  typedef struct packed {
    logic             req;
    logic [VEC_W-1:0] vec;
  } irq_t;

endpackage

//--- verilog/sound_host_regs.sv
// sound host register port
// decodes host writes into the mode, N and DA registers and returns
// MD or RG read data one CLK after the read request

`timescale 1ns/1ps

module sound_host_regs
  import sound_pkg::*;
(
  input  logic             CLK,
  input  logic             rst,
  input  reg_wr_t          reg_wr,
  input  reg_rd_t          reg_rd,
  input  logic [PNC_W-1:0] pnc,
  output md_fields_t       md,
  output logic [N_W-1:0]   n,
  output logic             da_wr_valid,
  output da_word_t         da_word,
  output logic [7:0]       rd_data,
  output logic             rd_valid
);

  logic [1:0]     ns_rate_q;
  logic           time_ie_q;
  logic           nss_q;
  logic           ns_ie_q;
  logic           tone_ie_q;
  logic [N_W-1:0] n_q;
  logic [7:0]     rd_mux;

  ////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge CLK) begin
    if (rst) begin
      ns_rate_q <= '0;
      time_ie_q <= 1'b0;
      nss_q     <= 1'b0;
      ns_ie_q   <= 1'b0;
      tone_ie_q <= 1'b0;
      n_q       <= '0;
    end else if (reg_wr.valid) begin
      case (reg_wr.addr)
        ADDR_MD: begin
          ns_rate_q <= reg_wr.data.md.ns_rate;
          time_ie_q <= reg_wr.data.md.time_ie;
          nss_q     <= reg_wr.data.md.nss_unused;
          ns_ie_q   <= reg_wr.data.md.ns_ie;
          tone_ie_q <= reg_wr.data.md.tone_ie;
        end
        ADDR_N:  n_q <= reg_wr.data[N_W-1:0];
        default: ;  // DA goes straight to the DAC, RG ignores writes
      endcase
    end
  end

  always_comb begin
    md            = '0;
    md.ns_rate    = ns_rate_q;
    md.time_ie    = time_ie_q;
    md.nss_unused = nss_q;
    md.ns_ie      = ns_ie_q;
    md.tone_ie    = tone_ie_q;
  end

  assign n           = n_q;
  assign da_wr_valid = reg_wr.valid && (reg_wr.addr == ADDR_DA);
  assign da_word     = reg_wr.data.da;

  ////////////////////////////////////////////////////////////
  // read side, fixed one CLK latency

  always_comb begin
    case (reg_rd.addr)
      // ns_rate on top, enables in the low nibble
      ADDR_MD: rd_mux = {ns_rate_q, 2'b00, time_ie_q, nss_q, ns_ie_q, tone_ie_q};
      ADDR_RG: rd_mux = {{(8 - PNC_W){1'b0}}, pnc};
      default: rd_mux = '0;  // N and DA are write only
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= reg_rd.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (reg_rd.valid) rd_data <= rd_mux;
  end

endmodule

//--- verilog/sound_timebase.sv
// sound timebase
// machine-cycle divider, free-running 9-bit timer, and the TIME and
// NS trigger pulses taken from falling edges of timer bits

`timescale 1ns/1ps

module sound_timebase
  import sound_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic [1:0] ns_rate,
  output logic       tick,
  output logic       time_trig,
  output logic       ns_trig
);

  logic [$clog2(CYCLE_CLKS)-1:0] div;
  logic [TC_W-1:0]               tc;
  logic                          ns_sel;
  logic                          ns_sel_d;
  logic                          tc_msb_d;

  ////////////////////////////////////////////////////////////
  // cycle divider

  assign tick = (div == ($clog2(CYCLE_CLKS))'(CYCLE_CLKS - 1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      div <= '0;
    end else if (tick) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // timer and trigger edges

  // NS rate picks one timer bit
  always_comb begin
    case (ns_rate)
      2'd0:    ns_sel = tc[8];   // 512 ticks
      2'd1:    ns_sel = tc[7];   // 256 ticks
      2'd2:    ns_sel = tc[5];
      default: ns_sel = tc[4];   // 32 ticks
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      tc       <= '0;
      tc_msb_d <= 1'b0;
      ns_sel_d <= 1'b0;
    end else if (tick) begin
      tc       <= tc + 1'b1;
      tc_msb_d <= tc[TC_W-1];   // one tick behind
      ns_sel_d <= ns_sel;
    end
  end

  // falling edge seen one tick later, pulse lands on the tick
  assign time_trig = tick & tc_msb_d & ~tc[TC_W-1];
  assign ns_trig   = tick & ns_sel_d & ~ns_sel;

endmodule

//--- verilog/tone_counter.sv
// tone counter
// N down-counter with reload counter; the range class of N picks
// which signal drives the TONE trigger on its falling edge

`timescale 1ns/1ps

module tone_counter
  import sound_pkg::*;
(
  input  logic           CLK,
  input  logic           rst,
  input  logic           tick,
  input  logic [N_W-1:0] n,
  output logic           tone_trig,
  output tone_range_e    range
);

  logic [N_W-1:0]   nc;      // down-counter
  logic [NUC_W-1:0] nuc;     // counts reloads
  logic             reload;
  logic             reload_d;
  logic             cond;
  logic             cond_d;

  assign reload = (nc == N_W'(1));

  always_ff @(posedge CLK) begin
    if (rst) begin
      nc       <= '0;
      nuc      <= '0;
      reload_d <= 1'b0;
      cond_d   <= 1'b0;
    end else if (tick) begin
      nc       <= reload ? n : nc - 1'b1;
      reload_d <= reload;
      cond_d   <= cond;
      if (reload_d) nuc <= nuc + 1'b1;   // one tick after the reload
    end
  end

  ////////////////////////////////////////////////////////////
  // range class and trigger source

  always_comb begin
    if (n < 8'h08) range = RANGE_00_07;
    else if (n < 8'h10) range = RANGE_08_0F;
    else if (n < 8'h20) range = RANGE_10_1F;
    else if (n < 8'h40) range = RANGE_20_3F;
    else range = RANGE_40_FF;
  end

  always_comb begin
    case (range)
      RANGE_08_0F: cond = nuc[2];
      RANGE_10_1F: cond = nuc[1];
      RANGE_20_3F: cond = nuc[0];
      RANGE_40_FF: cond = reload_d;
      default:     cond = 1'b0;   // lowest range never fires
    endcase
  end

  assign tone_trig = tick & cond_d & ~cond;

endmodule

//--- verilog/noise_lfsr.sv
// noise LFSR (PNC1)
// 7-bit shift register stepped by each NS trigger, readable as RG

`timescale 1ns/1ps

module noise_lfsr
  import sound_pkg::*;
(
  input  logic             CLK,
  input  logic             rst,
  input  logic             ns_trig,
  output logic [PNC_W-1:0] pnc
);

  logic feedback;

  // xnor of the top two taps, so an all-zero state still moves
  assign feedback = ~(pnc[5] ^ pnc[6]);

  always_ff @(posedge CLK) begin
    if (rst) begin
      pnc <= '0;
    end else if (ns_trig) begin
      pnc <= {pnc[PNC_W-2:0], feedback};
    end
  end

endmodule

//--- verilog/sound_int_ctrl.sv
// sound interrupt controller
// pending and active state per source with fixed priority TONE > NS > TIME,
// vector latched on activation and cleared by the host acknowledge

`timescale 1ns/1ps

module sound_int_ctrl
  import sound_pkg::*;
(
  input  logic        CLK,
  input  logic        rst,
  input  logic        tone_trig,
  input  logic        ns_trig,
  input  logic        time_trig,
  input  md_fields_t  md,
  input  tone_range_e range,
  input  logic        int_ack,
  output irq_t        irq
);

  // one bit per source indexed by int_src_e
  logic [2:0]       set_pend;
  logic [2:0]       pend_q;
  logic [2:0]       pend_now;
  logic [2:0]       act_q;
  logic [2:0]       grant;
  logic [VEC_W-1:0] grant_vec;
  logic [VEC_W-1:0] vec_q;

  assign set_pend[INT_TONE] = tone_trig & md.tone_ie;
  assign set_pend[INT_NS]   = ns_trig & md.ns_ie;
  assign set_pend[INT_TIME] = time_trig & md.time_ie;

  // an active source does not re-arm itself
  assign pend_now = pend_q | (set_pend & ~act_q);

  ////////////////////////////////////////////////////////////
  // priority select and vector

  always_comb begin
    grant = '0;
    if (!(|act_q)) begin
      if (pend_now[INT_TONE]) grant[INT_TONE] = 1'b1;
      else if (pend_now[INT_NS]) grant[INT_NS] = 1'b1;
      else if (pend_now[INT_TIME]) grant[INT_TIME] = 1'b1;
    end
  end

  always_comb begin
    grant_vec = VEC_TIME;
    if (grant[INT_TONE]) begin
      case (range)
        RANGE_10_1F: grant_vec = VEC_TONE + 8'h04;
        RANGE_20_3F: grant_vec = VEC_TONE + 8'h08;
        RANGE_40_FF: grant_vec = VEC_TONE + 8'h0C;
        default:     grant_vec = VEC_TONE;
      endcase
    end else if (grant[INT_NS]) begin
      grant_vec = VEC_NS;
    end
  end

  ////////////////////////////////////////////////////////////
  // state

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend_q <= '0;
      act_q  <= '0;
    end else begin
      pend_q <= pend_now & ~grant;    // going active clears pending
      if (|grant) begin
        act_q <= grant;               // only granted while nothing is active
      end else if (int_ack) begin
        act_q <= '0;
      end
    end
  end

  // latched at activation so a later N write cannot move it
  always_ff @(posedge CLK) begin
    if (|grant) vec_q <= grant_vec;
  end

  assign irq.req = |act_q;
  assign irq.vec = vec_q;

endmodule

//--- verilog/dac_output.sv
// DAC output stage
// holds the DA sample word and converts it to a 9-bit two's
// complement PCM value

`timescale 1ns/1ps

module dac_output
  import sound_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       da_wr_valid,
  input  da_word_t   da_word,
  output logic [8:0] pcm_out
);

  da_word_t   da_q;
  logic [7:0] level;

  always_ff @(posedge CLK) begin
    if (rst) begin
      da_q <= '0;
    end else if (da_wr_valid) begin
      da_q <= da_word;
    end
  end

  assign level = da_q.invert ? ~da_q.magnitude : da_q.magnitude;

  // negative half: sign bit set, level complemented again
  assign pcm_out = da_q.neg ? {1'b1, ~level} : {1'b0, level};

endmodule

//--- verilog/sound_top.sv
// sound and timing peripheral, top level
// host register port, timebase, tone counter, noise LFSR,
// interrupt controller and DAC output

`timescale 1ns/1ps

module sound_top
  import sound_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  reg_wr_t    reg_wr,
  input  reg_rd_t    reg_rd,
  output logic [7:0] rd_data,
  output logic       rd_valid,
  input  logic       int_ack,
  output irq_t       irq,
  output logic [8:0] pcm_out
);

  md_fields_t       md;
  logic [N_W-1:0]   n;
  logic [PNC_W-1:0] pnc;
  logic             da_wr_valid;
  da_word_t         da_word;
  logic             tick;
  logic             time_trig;
  logic             ns_trig;
  logic             tone_trig;
  tone_range_e      range;

  sound_host_regs u_regs (
    .CLK(CLK), .rst(rst), .reg_wr(reg_wr), .reg_rd(reg_rd), .pnc(pnc),
    .md(md), .n(n), .da_wr_valid(da_wr_valid), .da_word(da_word),
    .rd_data(rd_data), .rd_valid(rd_valid)
  );

  sound_timebase u_timebase (
    .CLK(CLK), .rst(rst), .ns_rate(md.ns_rate),
    .tick(tick), .time_trig(time_trig), .ns_trig(ns_trig)
  );

  tone_counter u_tone (
    .CLK(CLK), .rst(rst), .tick(tick), .n(n),
    .tone_trig(tone_trig), .range(range)
  );

  noise_lfsr u_noise (.CLK(CLK), .rst(rst), .ns_trig(ns_trig), .pnc(pnc));

  sound_int_ctrl u_int (
    .CLK(CLK), .rst(rst), .tone_trig(tone_trig), .ns_trig(ns_trig),
    .time_trig(time_trig), .md(md), .range(range), .int_ack(int_ack),
    .irq(irq)
  );

  dac_output u_dac (
    .CLK(CLK), .rst(rst), .da_wr_valid(da_wr_valid), .da_word(da_word),
    .pcm_out(pcm_out)
  );

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock and reset
// 40 ns clock, reset held high for the first two rising edges

`timescale 1ns/1ps

module tb_clk_gen (
  output logic CLK,
  output logic rst
);

  localparam int HALF_PERIOD = 20;  // ns

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge CLK);
    rst <= 1'b0;
  end

endmodule

//--- tb/tb_sound_top.sv
// testbench for the sound peripheral
// replays register operations from the stimulus file and checks DAC
// output, register read-back and interrupt vectors against values
// worked out from the conversion, LFSR and priority rules

`timescale 1ns/1ps

module tb_sound_top
  import sound_pkg::*;
();

  logic       CLK;
  logic       rst;
  reg_wr_t    reg_wr;
  reg_rd_t    reg_rd;
  logic [7:0] rd_data;
  logic       rd_valid;
  logic       int_ack;
  irq_t       irq;
  logic [8:0] pcm_out;

  int          err_count;
  int          check_count;
  int          test_count;
  int          test_errs;    // error count when the current test began
  bit          aborted;
  logic [31:0] lcg_state;

  localparam int NS_WAIT = 600;  // CLKs, NS period at rate 3 is 256

  tb_clk_gen u_clk (.CLK(CLK), .rst(rst));

  sound_top uut (
    .CLK(CLK), .rst(rst), .reg_wr(reg_wr), .reg_rd(reg_rd),
    .rd_data(rd_data), .rd_valid(rd_valid), .int_ack(int_ack),
    .irq(irq), .pcm_out(pcm_out)
  );

  ////////////////////////////////////////////////////////////
  // reference models

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // sign-magnitude style DA word to 9-bit two's complement
  function automatic logic [8:0] dac_expect(input logic [9:0] word);
    int lvl;
    lvl = word[9] ? 255 - word[7:0] : word[7:0];
    if (word[8]) return 9'(-(lvl + 1));  // negative half, one below
    return 9'(lvl);
  endfunction

  function automatic logic [PNC_W-1:0] lfsr_next(input logic [PNC_W-1:0] s);
    logic fb;
    fb = (s[5] == s[6]);  // taps equal gives a one
    return {s[PNC_W-2:0], fb};
  endfunction

  ////////////////////////////////////////////////////////////
  // host port tasks

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [9:0] data);
    reg_wr_t w;
    w.valid = 1'b1;
    w.addr  = reg_addr_e'(addr);
    w.data  = wr_data_u'(data);
    @(posedge CLK);
    reg_wr <= w;
    @(posedge CLK);        // DUT takes the write here
    reg_wr.valid <= 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] addr, output logic [7:0] data);
    @(posedge CLK);
    reg_rd <= '{valid: 1'b1, addr: reg_addr_e'(addr)};
    @(posedge CLK);
    reg_rd.valid <= 1'b0;
    @(negedge CLK);        // one CLK after the request edge
    compare("rd_valid", rd_valid, 1);
    data = rd_data;
  endtask

  task automatic ack_irq();
    @(posedge CLK);
    int_ack <= 1'b1;
    @(posedge CLK);
    int_ack <= 1'b0;
    @(negedge CLK);
    compare("irq.req", irq.req, 0);
  endtask

  task automatic wait_irq(input int limit, output bit ok);
    int cnt;
    cnt = 0;
    @(negedge CLK);
    while (irq.req !== 1'b1 && cnt < limit) begin
      @(negedge CLK);
      cnt++;
    end
    ok = (irq.req === 1'b1);
    if (!ok) begin
      $display("timeout at %0t ns: no interrupt request within %0d clocks", $time, limit);
      aborted = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compound operations

  task automatic random_dac(input int count);
    logic [9:0] word;
    for (int i = 0; i < count; i++) begin
      lcg_state = lcg_next(lcg_state);
      word = lcg_state[25:16];
      write_reg(ADDR_DA, word);
      @(negedge CLK);
      compare("pcm_out", pcm_out, dac_expect(word));
    end
  endtask

  // k-th NS interrupt, then RG must hold the k-th state from zero
  task automatic ns_sequence(input int count, input logic [7:0] vec);
    logic [PNC_W-1:0] state;
    logic [7:0]       rd;
    bit               ok;
    state = '0;
    for (int k = 1; k <= count && !aborted; k++) begin
      wait_irq(NS_WAIT, ok);
      if (ok) begin
        compare("irq.vec", irq.vec, vec);
        state = lfsr_next(state);
        ack_irq();
        read_reg(ADDR_RG, rd);
        compare("rg", rd, state);
      end
    end
  endtask

  task automatic finish_test(input int num);
    test_count++;
    if (err_count == test_errs) $display("test %0d: ok", num);
    else $display("test %0d: %0d errors", num, err_count - test_errs);
    test_errs = err_count;
  endtask

  task automatic run_op(input logic [31:0] op, input logic [31:0] addr,
                        input logic [31:0] data, input logic [31:0] exp);
    logic [7:0] rd;
    bit         ok;
    case (op)
      0: finish_test(data);
      1: write_reg(addr[1:0], data[9:0]);
      2: begin
        read_reg(addr[1:0], rd);
        compare("rd_data", rd, exp);
      end
      3: begin
        write_reg(addr[1:0], data[9:0]);
        @(negedge CLK);
        compare("pcm_out", pcm_out, exp);
      end
      4: random_dac(data);
      5: begin
        wait_irq(data, ok);
        if (ok) compare("irq.vec", irq.vec, exp);
      end
      6: ack_irq();
      7: repeat (data) @(posedge CLK);  // keep the active interrupt
      8: ns_sequence(data, exp[7:0]);
      9: begin
        @(negedge CLK);
        compare("pcm_out", pcm_out, exp);
        compare("irq.req", irq.req, 0);
      end
      default: begin
        $display("unknown operation %0h in the stimulus file", op);
        aborted = 1'b1;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin : main
    int             fd;
    int             cnt;
    logic [8*128-1:0] line;
    logic [31:0]    op;
    logic [31:0]    addr;
    logic [31:0]    data;
    logic [31:0]    exp;
    reg_wr      = '0;
    reg_rd      = '0;
    int_ack     = 1'b0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    test_errs   = 0;
    aborted     = 1'b0;
    lcg_state   = 32'h7c05;

    cnt = 0;
    while (rst !== 1'b0 && cnt < 20) begin
      @(posedge CLK);
      cnt++;
    end
    if (rst !== 1'b0) begin
      $display("reset was never released");
      aborted = 1'b1;
    end

    fd = $fopen("tb/sound_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file tb/sound_stim.txt");
      aborted = 1'b1;
    end else begin
      while (!aborted && !$feof(fd)) begin
        // comment and blank lines scan short and are skipped
        if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %h %h", op, addr, data, exp) == 4)
          run_op(op, addr, data, exp);
      end
      $fclose(fd);
    end

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (aborted || err_count != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

//--- tb/sound_stim.txt
// columns: op addr data expect, all hex; tests 1 2 5 3 4 6 in that order
// op 0 end test, 1 write, 2 read, 3 DA write, 4 random DA, 5 wait irq, 6 ack, 7 hold, 8 NS run, 9 idle
9 0 000 000
2 0 000 00
0 0 001 0
3 2 000 000
3 2 07F 07F
3 2 2F0 00F
3 2 155 1AA
3 2 380 180
4 2 010 0
0 0 002 0
1 0 302 0
2 0 000 C2
8 0 006 48
1 0 000 0
0 0 005 0
1 0 008 0
5 0 1068 80
6 0 000 0
0 0 003 0
1 1 050 0
1 0 001 0
5 0 1068 2C
6 0 000 0
1 1 018 0
5 0 1068 24
6 0 000 0
0 0 004 0
1 1 050 0
5 0 1068 2C
1 0 009 0
7 0 1068 0
6 0 000 0
5 0 0010 80
6 0 000 0
5 0 1068 2C
6 0 000 0
0 0 006 0

//--- vlog.f
verilog/sound_pkg.sv
verilog/sound_host_regs.sv
verilog/sound_timebase.sv
verilog/tone_counter.sv
verilog/noise_lfsr.sv
verilog/sound_int_ctrl.sv
verilog/dac_output.sv
verilog/sound_top.sv
tb/tb_clk_gen.sv
tb/tb_sound_top.sv

//--- Bender.yml
package:
  name: sound_top

sources:
  - verilog/sound_pkg.sv
  - verilog/sound_host_regs.sv
  - verilog/sound_timebase.sv
  - verilog/tone_counter.sv
  - verilog/noise_lfsr.sv
  - verilog/sound_int_ctrl.sv
  - verilog/dac_output.sv
  - verilog/sound_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_sound_top.sv
